// File: core_shell.f
bridge_pkg.sv
video_pkg.sv
settings_if.sv
core_settings_bank.sv
save_size_reporter.sv
video_sync_shaper.sv
core_shell.sv
tb_core_shell.sv

// File: Makefile
TOP = tb_core_shell
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f core_shell.f --top-module core_shell

sim:
	verilator --binary --timing --assert -Wno-fatal -f core_shell.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_core_shell.sv
////////////////////
// testbench for the core shell
// drives bridge writes, save info and video on the falling edge
// concurrent assertions compare the outputs with a reference model
////////////////////

`timescale 1ns/1ps

module tb_core_shell;

  localparam int RESET_HOLD  = 20;
  localparam int HSYNC_DELAY = 7;
  localparam int HALF_PERIOD = 50;
  localparam int CLK_PERIOD  = 2 * HALF_PERIOD;
  // cycle budgets per test, the watchdog adds them up
  localparam int BUDGET_TOTAL = 10 + 60 + 30 + 40 + 90 + 40;
  localparam int WATCHDOG_CYCLES = BUDGET_TOTAL + 50;

  logic        clk_74a;
  logic        pll_core_locked;
  logic [31:0] bridge_addr;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic        h_blank;
  logic        v_blank;
  logic        hsync_core;
  logic        vsync_core;
  logic [23:0] rgb_core;
  logic        is_vertical;
  logic [11:0] save_size;
  logic        has_rtc;
  logic        external_reset;
  logic [1:0]  configured_system;
  logic        use_cpu_turbo;
  logic        use_triple_buffer;
  logic [1:0]  configured_flickerblend;
  logic [1:0]  configured_orientation;
  logic        use_flip_horizontal;
  logic        use_fastforward_sound;
  logic        datatable_wren;
  logic [9:0]  datatable_addr;
  logic [31:0] datatable_data;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic [23:0] video_rgb;

  // reference model state
  logic        exp_ext_reset = 1'b0;
  logic [1:0]  exp_system = 2'd0;
  logic        exp_turbo = 1'b0;
  logic        exp_triple = 1'b0;
  logic [1:0]  exp_flicker = 2'd0;
  logic [1:0]  exp_orient = 2'd0;
  logic        exp_flip = 1'b0;
  logic        exp_ff_sound = 1'b0;
  logic [31:0] exp_data = '0;
  logic        exp_de = 1'b0;
  logic [23:0] exp_rgb = '0;
  logic        exp_hs = 1'b0;
  logic        exp_vs = 1'b0;
  logic        model_de_prev = 1'b0;
  logic        model_hs_prev = 1'b0;
  logic        model_vs_prev = 1'b0;
  int          hs_wait = 0;
  logic        dt_check = 1'b0;
  logic        video_chk = 1'b0;
  logic [15:0] lfsr_state = 16'd49;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  string       cur_test = "reset";

  wire [9:0] settings_act = {configured_system, use_cpu_turbo, use_triple_buffer,
                             configured_flickerblend, configured_orientation,
                             use_flip_horizontal, use_fastforward_sound};
  wire [9:0] settings_exp = {exp_system, exp_turbo, exp_triple, exp_flicker,
                             exp_orient, exp_flip, exp_ff_sound};
  wire [14:0] reset_view = {settings_act, external_reset, datatable_wren,
                            video_de, video_hs, video_vs};

  core_shell #(
    .RESET_HOLD  (RESET_HOLD),
    .HSYNC_DELAY (HSYNC_DELAY)
  ) dut_i (.*);

  initial begin
    clk_74a = 1'b0;
    forever #HALF_PERIOD clk_74a = ~clk_74a;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  ////////////////////
  // helpers

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("Fail %s %s expected %0h actual %0h", cur_test, what, exp, act);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("test %s: %s, %0d errors", cur_test,
             (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
  endtask

  // register effect of one bridge write
  task automatic apply_write(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      bridge_pkg::ADDR_RESET_REQ:    exp_ext_reset = 1'b1;
      bridge_pkg::ADDR_SYSTEM:       exp_system = data[1:0];
      bridge_pkg::ADDR_CPU_TURBO:    exp_turbo = data[0];
      bridge_pkg::ADDR_TRIPLE_BUF:   exp_triple = data[0];
      bridge_pkg::ADDR_FLICKERBLEND: exp_flicker = data[1:0];
      bridge_pkg::ADDR_ORIENTATION:  exp_orient = data[1:0];
      bridge_pkg::ADDR_FLIP_HORIZ:   exp_flip = data[0];
      bridge_pkg::ADDR_FF_SOUND:     exp_ff_sound = data[0];
      default: begin
      end
    endcase
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    apply_write(addr, data);
  endtask

  function automatic logic [23:0] slot_code();
    logic vertical;
    case (exp_orient)
      2'd0:    vertical = is_vertical;
      2'd2:    vertical = 1'b1;
      default: vertical = 1'b0;
    endcase
    return 24'(vertical) << video_pkg::SLOT_ORIENT_BIT;
  endfunction

  // model update for the inputs sampled at the last edge, then new inputs
  task automatic video_cycle(input logic hb, input logic vb, input logic hs,
                             input logic vs, input logic [23:0] rgb);
    logic de_now;
    @(negedge clk_74a);
    de_now = !(h_blank || v_blank);
    exp_de = de_now;
    exp_rgb = de_now ? rgb_core : (model_de_prev ? slot_code() : 24'd0);
    model_de_prev = de_now;
    exp_vs = vsync_core && !model_vs_prev;
    model_vs_prev = vsync_core;
    if (hs_wait != 0) begin
      hs_wait--;
      exp_hs = (hs_wait == 0);
    end else begin
      exp_hs = 1'b0;
    end
    if (hsync_core && !model_hs_prev) begin
      hs_wait = HSYNC_DELAY - 1;
    end
    model_hs_prev = hsync_core;
    h_blank = hb;
    v_blank = vb;
    hsync_core = hs;
    vsync_core = vs;
    rgb_core = rgb;
  endtask

  task automatic drive_line(input int pixels);
    logic [31:0] r;
    repeat (2) video_cycle(1'b1, 1'b0, 1'b0, 1'b0, 24'd0);
    for (int i = 0; i < pixels; i++) begin
      take_bits(24, r);
      video_cycle(1'b0, 1'b0, 1'b0, 1'b0, r[23:0]);
    end
    repeat (3) video_cycle(1'b1, 1'b0, 1'b0, 1'b0, 24'd0);
  endtask

  ////////////////////
  // checks

  a_reset_state: assert property (@(posedge clk_74a) $rose(pll_core_locked) |-> reset_view == '0)
    else report_value("reset_state", 64'd0, 64'($sampled(reset_view)));

  a_settings: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settings_act == settings_exp)
    else report_value("settings", 64'($sampled(settings_exp)), 64'($sampled(settings_act)));

  a_ext_reset: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    external_reset == exp_ext_reset)
    else report_value("external_reset", 64'($sampled(exp_ext_reset)),
                      64'($sampled(external_reset)));

  a_datatable: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    dt_check |-> {datatable_wren, datatable_addr, datatable_data} == {1'b1, 10'd7, exp_data})
    else report_value("datatable", 64'({1'b1, 10'd7, $sampled(exp_data)}),
                      64'({$sampled(datatable_wren), $sampled(datatable_addr),
                           $sampled(datatable_data)}));

  a_video_pixels: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_chk |-> {video_de, video_rgb} == {exp_de, exp_rgb})
    else report_value("video_de_rgb", 64'({$sampled(exp_de), $sampled(exp_rgb)}),
                      64'({$sampled(video_de), $sampled(video_rgb)}));

  a_video_hs: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_chk |-> video_hs == exp_hs)
    else report_value("video_hs", 64'($sampled(exp_hs)), 64'($sampled(video_hs)));

  a_video_vs: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_chk |-> video_vs == exp_vs)
    else report_value("video_vs", 64'($sampled(exp_vs)), 64'($sampled(video_vs)));

  a_sync_apart: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !(video_hs && video_vs))
    else begin
      errors++;
      $display("hsync and vsync pulses overlap during test %s", cur_test);
    end

  ////////////////////
  // test sequence

  initial begin
    logic [31:0] r;
    bridge_pkg::setting_addr_e map_addrs [7] = '{
      bridge_pkg::ADDR_SYSTEM, bridge_pkg::ADDR_CPU_TURBO, bridge_pkg::ADDR_TRIPLE_BUF,
      bridge_pkg::ADDR_FLICKERBLEND, bridge_pkg::ADDR_ORIENTATION,
      bridge_pkg::ADDR_FLIP_HORIZ, bridge_pkg::ADDR_FF_SOUND};
    logic [31:0] unmapped [4] = '{32'h054, 32'h104, 32'h210, 32'h1000_0200};
    logic [1:0] orient_list [4] = '{2'd0, 2'd0, 2'd2, 2'd1};
    logic vert_list [4] = '{1'b0, 1'b1, 1'b0, 1'b1};
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    h_blank = 1'b1;
    v_blank = 1'b1;
    hsync_core = 1'b0;
    vsync_core = 1'b0;
    rgb_core = '0;
    is_vertical = 1'b0;
    save_size = '0;
    has_rtc = 1'b0;

    start_test("reset");
    repeat (5) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    repeat (2) @(negedge clk_74a);
    finish_test();

    start_test("settings");
    for (int pass = 0; pass < 3; pass++) begin
      foreach (map_addrs[i]) begin
        take_bits(32, r);
        bus_write(map_addrs[i], r);
      end
    end
    foreach (unmapped[i]) begin
      take_bits(32, r);
      bus_write(unmapped[i], r);
    end
    finish_test();

    start_test("reset_hold");
    bus_write(bridge_pkg::ADDR_RESET_REQ, 32'd1);
    repeat (RESET_HOLD) @(negedge clk_74a);
    exp_ext_reset = 1'b0;
    repeat (3) @(negedge clk_74a);
    finish_test();

    start_test("save_size");
    for (int i = 0; i < 13; i++) begin
      @(negedge clk_74a);
      // outputs now carry the inputs of the last edge
      exp_data = 32'(save_size) * 32'd512 + (has_rtc ? 32'd12 : 32'd0);
      dt_check = 1'b1;
      take_bits(13, r);
      save_size = r[12:1];
      has_rtc = r[0];
    end
    @(negedge clk_74a);
    exp_data = 32'(save_size) * 32'd512 + (has_rtc ? 32'd12 : 32'd0);
    repeat (2) @(negedge clk_74a);
    finish_test();

    start_test("video_lines");
    video_chk = 1'b1;
    for (int c = 0; c < 4; c++) begin
      bus_write(bridge_pkg::ADDR_ORIENTATION, 32'(orient_list[c]));
      is_vertical = vert_list[c];
      drive_line(8);
    end
    finish_test();

    start_test("video_sync");
    repeat (3) video_cycle(1'b1, 1'b1, 1'b1, 1'b1, 24'd0);
    repeat (10) video_cycle(1'b1, 1'b1, 1'b0, 1'b0, 24'd0);
    repeat (2) video_cycle(1'b1, 1'b1, 1'b1, 1'b0, 24'd0);
    repeat (10) video_cycle(1'b1, 1'b1, 1'b0, 1'b0, 24'd0);
    finish_test();

    $display("tests run %0d, checks failed %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: core_shell.sv
////////////////////
// control and video conditioning shell around the console core
// bridge settings, save size report and scaler video on clk_74a
////////////////////

`timescale 1ns/1ps

module core_shell #(
  parameter int RESET_HOLD  = bridge_pkg::DEFAULT_RESET_HOLD,
  parameter int HSYNC_DELAY = video_pkg::HSYNC_DELAY_DEFAULT
) (
  input  logic                                clk_74a,
  input  logic                                pll_core_locked,
  // host bridge
  input  logic [bridge_pkg::BRIDGE_WIDTH-1:0] bridge_addr,
  input  logic                                bridge_wr,
  input  logic [bridge_pkg::BRIDGE_WIDTH-1:0] bridge_wr_data,
  // raw core video
  input  logic                                h_blank,
  input  logic                                v_blank,
  input  logic                                hsync_core,
  input  logic                                vsync_core,
  input  video_pkg::rgb_t                     rgb_core,
  input  logic                                is_vertical,
  // save info from the core
  input  logic [11:0]                         save_size,
  input  logic                                has_rtc,
  // settings to the core
  output logic                                external_reset,
  output logic [1:0]                          configured_system,
  output logic                                use_cpu_turbo,
  output logic                                use_triple_buffer,
  output logic [1:0]                          configured_flickerblend,
  output logic [1:0]                          configured_orientation,
  output logic                                use_flip_horizontal,
  output logic                                use_fastforward_sound,
  // host data table
  output logic                                datatable_wren,
  output logic [9:0]                          datatable_addr,
  output logic [bridge_pkg::BRIDGE_WIDTH-1:0] datatable_data,
  // scaler video
  output logic                                video_de,
  output logic                                video_hs,
  output logic                                video_vs,
  output video_pkg::rgb_t                     video_rgb
);

  settings_if settings ();

  core_settings_bank #(
    .RESET_HOLD (RESET_HOLD)
  ) settings_bank_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .settings        (settings)
  );

  save_size_reporter save_reporter_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .save_size       (save_size),
    .has_rtc         (has_rtc),
    .datatable_wren  (datatable_wren),
    .datatable_addr  (datatable_addr),
    .datatable_data  (datatable_data)
  );

  video_sync_shaper #(
    .HSYNC_DELAY (HSYNC_DELAY)
  ) video_shaper_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .hsync_core      (hsync_core),
    .vsync_core      (vsync_core),
    .rgb_core        (rgb_core),
    .is_vertical     (is_vertical),
    .settings        (settings),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

  // settings fanned out to the core pins
  assign external_reset          = settings.external_reset;
  assign configured_system       = settings.configured_system;
  assign use_cpu_turbo           = settings.use_cpu_turbo;
  assign use_triple_buffer       = settings.use_triple_buffer;
  assign configured_flickerblend = settings.configured_flickerblend;
  assign configured_orientation  = settings.configured_orientation;
  assign use_flip_horizontal     = settings.use_flip_horizontal;
  assign use_fastforward_sound   = settings.use_fastforward_sound;

endmodule

// File: video_sync_shaper.sv
////////////////////
// conditions raw core video for the scaler
// registered pixels, delayed hsync, one cycle vsync, orientation slot code
////////////////////

`timescale 1ns/1ps

module video_sync_shaper #(
  parameter int HSYNC_DELAY = video_pkg::HSYNC_DELAY_DEFAULT
) (
  input  logic            clk_74a,
  input  logic            pll_core_locked,
  input  logic            h_blank,
  input  logic            v_blank,
  input  logic            hsync_core,
  input  logic            vsync_core,
  input  video_pkg::rgb_t rgb_core,
  input  logic            is_vertical,
  settings_if.video       settings,
  output logic            video_de,
  output logic            video_hs,
  output logic            video_vs,
  output video_pkg::rgb_t video_rgb
);

  localparam int HS_W = $clog2(HSYNC_DELAY);
  localparam logic [HS_W-1:0] HS_LOAD = HS_W'(HSYNC_DELAY - 1);

  logic            de;
  logic            hs_prev;
  logic            vs_prev;
  logic            frame_vertical;
  logic [HS_W-1:0] hs_cnt;
  video_pkg::rgb_t slot_rgb;

  assign de = ~(h_blank | v_blank);

  // auto defers to the core
  always_comb begin
    case (settings.configured_orientation)
      video_pkg::ORIENT_AUTO:     frame_vertical = is_vertical;
      video_pkg::ORIENT_VERTICAL: frame_vertical = 1'b1;
      default:                    frame_vertical = 1'b0;
    endcase
  end

  always_comb begin
    slot_rgb = '0;
    slot_rgb[video_pkg::SLOT_ORIENT_BIT] = frame_vertical;
  end

  ////////////////////
  // sync and enable

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_cnt   <= '0;
    end else begin
      video_de <= de;
      hs_prev  <= hsync_core;
      vs_prev  <= vsync_core;
      // vsync pulse right on the core edge
      video_vs <= vsync_core & ~vs_prev;
      // hsync waits out the countdown
      video_hs <= (hs_cnt == HS_W'(1));
      if (hsync_core && !hs_prev) begin
        hs_cnt <= HS_LOAD;
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

  // pixel payload, slot code right after the line
  always_ff @(posedge clk_74a) begin
    if (de) begin
      video_rgb <= rgb_core;
    end else if (video_de) begin
      video_rgb <= slot_rgb;
    end else begin
      video_rgb <= '0;
    end
  end

  ////////////////////
  // checks

  a_vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else $error("vsync pulse longer than one cycle");

  a_hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else $error("hsync pulse longer than one cycle");

endmodule

// File: save_size_reporter.sv
////////////////////
// publishes the save RAM size in bytes to the host data table
// rewritten every cycle so it tracks the loaded cartridge
////////////////////

`timescale 1ns/1ps

module save_size_reporter (
  input  logic                                clk_74a,
  input  logic                                pll_core_locked,
  input  logic [11:0]                         save_size,
  input  logic                                has_rtc,
  output logic                                datatable_wren,
  output logic [9:0]                          datatable_addr,
  output logic [bridge_pkg::BRIDGE_WIDTH-1:0] datatable_data
);

  localparam int DW = bridge_pkg::BRIDGE_WIDTH;

  logic [DW-1:0] save_bytes;

  // block count to bytes, plus the rtc words when present
  assign save_bytes = DW'(save_size) * DW'(bridge_pkg::SAVE_BLOCK_BYTES)
                    + (has_rtc ? DW'(bridge_pkg::RTC_EXTRA_BYTES) : '0);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      datatable_addr <= 10'(bridge_pkg::DATATABLE_SAVE_SLOT);
      datatable_data <= save_bytes;
    end
  end

endmodule

// File: core_settings_bank.sv
////////////////////
// settings registers written by the host bridge
// also stretches a host reset request into a long core reset
////////////////////

`timescale 1ns/1ps

module core_settings_bank #(
  parameter int RESET_HOLD = bridge_pkg::DEFAULT_RESET_HOLD
) (
  input  logic                                clk_74a,
  input  logic                                pll_core_locked,
  input  logic [bridge_pkg::BRIDGE_WIDTH-1:0] bridge_addr,
  input  logic                                bridge_wr,
  input  logic [bridge_pkg::BRIDGE_WIDTH-1:0] bridge_wr_data,
  settings_if.bank                            settings
);

  localparam int CNT_W = $clog2(RESET_HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;
  logic             reset_req;

  assign reset_req = bridge_wr && (bridge_addr == bridge_pkg::ADDR_RESET_REQ);

  ////////////////////
  // reset stretch

  // a new request restarts the hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt                <= '0;
      settings.external_reset <= 1'b0;
    end else if (reset_req) begin
      hold_cnt                <= CNT_W'(RESET_HOLD);
      settings.external_reset <= 1'b1;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
      if (hold_cnt == CNT_W'(1)) begin
        settings.external_reset <= 1'b0;
      end
    end
  end

  ////////////////////
  // setting registers

  // unmapped addresses fall through
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings.configured_system       <= 2'd0;
      settings.use_cpu_turbo           <= 1'b0;
      settings.use_triple_buffer       <= 1'b0;
      settings.configured_flickerblend <= 2'd0;
      settings.configured_orientation  <= video_pkg::ORIENT_AUTO;
      settings.use_flip_horizontal     <= 1'b0;
      settings.use_fastforward_sound   <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        bridge_pkg::ADDR_SYSTEM:       settings.configured_system <= bridge_wr_data[1:0];
        bridge_pkg::ADDR_CPU_TURBO:    settings.use_cpu_turbo <= bridge_wr_data[0];
        bridge_pkg::ADDR_TRIPLE_BUF:   settings.use_triple_buffer <= bridge_wr_data[0];
        bridge_pkg::ADDR_FLICKERBLEND: settings.configured_flickerblend <= bridge_wr_data[1:0];
        bridge_pkg::ADDR_ORIENTATION: begin
          settings.configured_orientation <= video_pkg::orientation_e'(bridge_wr_data[1:0]);
        end
        bridge_pkg::ADDR_FLIP_HORIZ:   settings.use_flip_horizontal <= bridge_wr_data[0];
        bridge_pkg::ADDR_FF_SOUND:     settings.use_fastforward_sound <= bridge_wr_data[0];
        default: begin
        end
      endcase
    end
  end

  ////////////////////
  // checks

  a_hold_bounded: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    hold_cnt <= CNT_W'(RESET_HOLD))
    else $error("reset hold counter above its limit");

  // release only at the end of a full countdown
  a_reset_release: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $fell(settings.external_reset) |-> $past(hold_cnt) == CNT_W'(1))
    else $error("core reset released early");

endmodule

// File: settings_if.sv
////////////////////
// decoded core settings from the register bank to its consumers
// bank drives, video reads orientation, observe reads everything
////////////////////

`timescale 1ns/1ps

interface settings_if;

  logic                     external_reset;
  logic [1:0]               configured_system;
  logic                     use_cpu_turbo;
  logic                     use_triple_buffer;
  logic [1:0]               configured_flickerblend;
  video_pkg::orientation_e  configured_orientation;
  logic                     use_flip_horizontal;
  logic                     use_fastforward_sound;

  modport bank (
    output external_reset,
    output configured_system,
    output use_cpu_turbo,
    output use_triple_buffer,
    output configured_flickerblend,
    output configured_orientation,
    output use_flip_horizontal,
    output use_fastforward_sound
  );

  modport video (
    input configured_orientation
  );

  // top level view of all fields
  modport observe (
    input external_reset,
    input configured_system,
    input use_cpu_turbo,
    input use_triple_buffer,
    input configured_flickerblend,
    input configured_orientation,
    input use_flip_horizontal,
    input use_fastforward_sound
  );

endinterface

// File: video_pkg.sv
////////////////////
// video definitions shared by the shaper, the settings and the top level
// pixel type, orientation encoding and scaler slot code layout
////////////////////

package video_pkg;

  // 8 bits each of red, green, blue
  typedef logic [23:0] rgb_t;

  ////////////////////
  // orientation setting

  // value 3 is unused and handled as horizontal
  typedef enum logic [1:0] {
    ORIENT_AUTO       = 2'd0,
    ORIENT_HORIZONTAL = 2'd1,
    ORIENT_VERTICAL   = 2'd2
  } orientation_e;

  ////////////////////
  // scaler slot code

  // set selects the second scaler slot for rotated frames
  localparam int SLOT_ORIENT_BIT = 13;

  // hsync delay keeps the hsync pulse clear of vsync
  localparam int HSYNC_DELAY_DEFAULT = 7;

endpackage

// File: bridge_pkg.sv
////////////////////
// host bridge definitions shared by the settings bank and the save reporter
// byte addresses of the writable settings and data-table constants
////////////////////

package bridge_pkg;

  // address and data width of the host bridge
  localparam int BRIDGE_WIDTH = 32;

  ////////////////////
  // settings address map

  typedef enum logic [BRIDGE_WIDTH-1:0] {
    ADDR_RESET_REQ    = 32'h0000_0050,
    ADDR_SYSTEM       = 32'h0000_0100,
    ADDR_CPU_TURBO    = 32'h0000_0110,
    ADDR_TRIPLE_BUF   = 32'h0000_0200,
    ADDR_FLICKERBLEND = 32'h0000_0204,
    ADDR_ORIENTATION  = 32'h0000_0208,
    ADDR_FLIP_HORIZ   = 32'h0000_020C,
    ADDR_FF_SOUND     = 32'h0000_0300
  } setting_addr_e;

  // cycles the core reset stays high after a request
  localparam int DEFAULT_RESET_HOLD = 1_000_000;

  ////////////////////
  // data table

  // word index of the save slot size entry
  localparam int DATATABLE_SAVE_SLOT = 7;
  // save size comes in blocks of this many bytes
  localparam int SAVE_BLOCK_BYTES = 512;
  // six rtc words appended to the save
  localparam int RTC_EXTRA_BYTES = 12;

endpackage
